/* compile.f */
isaPkg.sv
pipePkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
cpuTop.sv
cpuTb.sv

/* Bender.yml */
package:
  name: cpu16

sources:
  - files:
      - isaPkg.sv
      - pipePkg.sv
      - fetchStage.sv
      - decodeStage.sv
      - executeStage.sv
      - memoryStage.sv
      - cpuTop.sv
  - target: test
    files:
      - cpuTb.sv

/* cpuTb.sv */
module cpuTb;

	localparam int imemWords = 64;
	localparam int dmemWords = 32;
	localparam int progLen = 40;
	localparam int waitLimit = 2000;

	typedef struct packed {
		isaPkg::regIdxT dest;
		isaPkg::wordT data;
	} commitT;

	typedef struct packed {
		isaPkg::wordT addr;
		isaPkg::wordT data;
	} storeT;

	logic clk = 1'b0;
	logic reset;
	logic progWrite;
	isaPkg::wordT progAddr;
	isaPkg::wordT progData;
	logic commitValid;
	isaPkg::regIdxT commitReg;
	isaPkg::wordT commitData;
	logic storeValid;
	isaPkg::wordT storeAddr;
	isaPkg::wordT storeData;
	logic halted;

	isaPkg::wordT prog [progLen];
	isaPkg::wordT modelRegs [8];
	isaPkg::wordT modelMem [dmemWords];
	commitT commitQ [$];
	storeT storeQ [$];
	commitT expCommit;
	storeT expStore;
	int commitErrs = 0;
	int storeErrs = 0;
	int otherErrs = 0;
	int resetEdges = 0;
	int cycles;
	int idx;
	logic haltNoted = 1'b0;

	cpuTop #(.imemWords(imemWords), .dmemWords(dmemWords)) u_cpuTop (
		.clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
		.progData(progData), .commitValid(commitValid), .commitReg(commitReg),
		.commitData(commitData), .storeValid(storeValid), .storeAddr(storeAddr),
		.storeData(storeData), .halted(halted)
	);

	always #10 clk = ~clk;

	// Branch offsets go forward only and the last slot is HALT
	task automatic buildProgram();
		int kind;
		int maxSkip;
		int skip;
		isaPkg::wordT r;
		for (int i = 0; i < progLen - 1; i++) begin
			kind = $urandom_range(19, 0);
			r = isaPkg::wordT'($urandom);
			maxSkip = (progLen - 2 - i > 4) ? 4 : progLen - 2 - i;
			skip = $urandom_range(maxSkip, 0);
			case (kind)
				5: prog[i] = {isaPkg::opAddi, r[10:0]};
				6: prog[i] = {isaPkg::opSubi, r[10:0]};
				7: prog[i] = {isaPkg::opXori, r[10:0]};
				8: prog[i] = {isaPkg::opAndni, r[10:0]};
				9, 10: prog[i] = {isaPkg::opLbi, r[10:0]};
				11, 12: prog[i] = {isaPkg::opLd, r[10:0]};
				13, 14: prog[i] = {isaPkg::opSt, r[10:0]};
				15: prog[i] = {isaPkg::opBeqz, r[10:8], 8'(skip * 2)};
				16: prog[i] = {isaPkg::opBnez, r[10:8], 8'(skip * 2)};
				17: prog[i] = {isaPkg::opJ, 11'(skip * 2)};
				18: prog[i] = {isaPkg::opNop, r[10:0]};
				default: prog[i] = {isaPkg::opRtype, r[10:0]};
			endcase
		end
		r = isaPkg::wordT'($urandom);
		prog[progLen-1] = {isaPkg::opHalt, r[10:0]};
	endtask

	task automatic writeBack(isaPkg::regIdxT dest, isaPkg::wordT value);
		commitT entry;
		modelRegs[dest] = value;
		entry.dest = dest;
		entry.data = value;
		commitQ.push_back(entry);
	endtask

	// In-order ISA model
	task automatic runModel();
		isaPkg::wordT pc;
		isaPkg::wordT inst;
		isaPkg::wordT a;
		isaPkg::wordT b;
		isaPkg::wordT addr;
		isaPkg::wordT sx5;
		isaPkg::wordT zx5;
		isaPkg::wordT sx8;
		isaPkg::wordT sx11;
		storeT st;
		logic done;
		int steps;
		for (int i = 0; i < 8; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < dmemWords; i++) begin
			modelMem[i] = '0;
		end
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 4 * progLen) begin
			inst = prog[pc >> 1];
			a = modelRegs[inst[10:8]];
			b = modelRegs[inst[7:5]];
			sx5 = {{11{inst[4]}}, inst[4:0]};
			zx5 = {11'b0, inst[4:0]};
			sx8 = {{8{inst[7]}}, inst[7:0]};
			sx11 = {{5{inst[10]}}, inst[10:0]};
			addr = a + sx5;
			pc = pc + 16'd2;
			steps++;
			case (isaPkg::opcodeT'(inst[15:11]))
				isaPkg::opHalt: done = 1'b1;
				isaPkg::opRtype: begin
					case (inst[1:0])
						2'b00: writeBack(inst[4:2], a + b);
						2'b01: writeBack(inst[4:2], b - a);
						2'b10: writeBack(inst[4:2], a ^ b);
						default: writeBack(inst[4:2], a & ~b);
					endcase
				end
				isaPkg::opAddi: writeBack(inst[7:5], a + sx5);
				isaPkg::opSubi: writeBack(inst[7:5], sx5 - a);
				isaPkg::opXori: writeBack(inst[7:5], a ^ zx5);
				isaPkg::opAndni: writeBack(inst[7:5], a & ~zx5);
				isaPkg::opLbi: writeBack(inst[10:8], sx8);
				isaPkg::opLd: writeBack(inst[7:5], modelMem[(addr >> 1) % dmemWords]);
				isaPkg::opSt: begin
					modelMem[(addr >> 1) % dmemWords] = b;
					st.addr = addr;
					st.data = b;
					storeQ.push_back(st);
				end
				isaPkg::opBeqz: if (a == '0) pc = pc + sx8;
				isaPkg::opBnez: if (a != '0) pc = pc + sx8;
				isaPkg::opJ: pc = pc + sx11;
				default: ;
			endcase
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			if (resetEdges > 0) begin
				quietInReset: assert (!commitValid && !storeValid && !halted) else begin
					otherErrs++;
					$display("Commit, store or halted output active during reset");
				end
			end
			resetEdges++;
		end else begin
			if (commitValid) begin
				commitAfterHalt: assert (!halted) else begin
					otherErrs++;
					$display("Register commit seen after halted");
				end
				commitExpected: assert (commitQ.size() > 0) else begin
					commitErrs++;
					$display("Register commit seen with none expected");
				end
				if (commitQ.size() > 0) begin
					expCommit = commitQ.pop_front();
					commitRegMatch: assert (commitReg === expCommit.dest) else begin
						commitErrs++;
						$display("ERR commitReg got 0x%h expected 0x%h", commitReg,
							expCommit.dest);
					end
					commitDataMatch: assert (commitData === expCommit.data) else begin
						commitErrs++;
						$display("ERR commitData got 0x%h expected 0x%h", commitData,
							expCommit.data);
					end
				end
			end
			if (storeValid) begin
				storeAfterHalt: assert (!halted) else begin
					otherErrs++;
					$display("Store seen after halted");
				end
				storeExpected: assert (storeQ.size() > 0) else begin
					storeErrs++;
					$display("Store seen with none expected");
				end
				if (storeQ.size() > 0) begin
					expStore = storeQ.pop_front();
					storeAddrMatch: assert (storeAddr === expStore.addr) else begin
						storeErrs++;
						$display("ERR storeAddr got 0x%h expected 0x%h", storeAddr,
							expStore.addr);
					end
					storeDataMatch: assert (storeData === expStore.data) else begin
						storeErrs++;
						$display("ERR storeData got 0x%h expected 0x%h", storeData,
							expStore.data);
					end
				end
			end
			// Halted may only rise once everything has retired
			if (halted && !haltNoted) begin
				haltNoted <= 1'b1;
				haltAfterLast: assert (commitQ.size() == 0 && storeQ.size() == 0) else begin
					otherErrs++;
					$display("halted rose with %0d commits and %0d stores outstanding",
						commitQ.size(), storeQ.size());
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		void'($urandom(32'haece0de8));
		buildProgram();
		runModel();
		// Program goes in while reset is high
		for (idx = 0; idx < progLen; idx++) begin
			@(negedge clk);
			progWrite = 1'b1;
			progAddr = isaPkg::wordT'(idx * 2);
			progData = prog[idx];
		end
		@(negedge clk);
		progWrite = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		cycles = 0;
		while (!halted && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			otherErrs++;
			$display("Timeout after %0d cycles waiting for halted", waitLimit);
		end
		// Watch for stray strobes past halt
		repeat (10) @(negedge clk);
		queuesDrained: assert (commitQ.size() == 0 && storeQ.size() == 0) else begin
			otherErrs++;
			$display("Run ended with %0d commits and %0d stores never seen",
				commitQ.size(), storeQ.size());
		end
		$display("Errors: commit %0d, store %0d, other %0d", commitErrs, storeErrs, otherErrs);
		if (commitErrs == 0 && storeErrs == 0 && otherErrs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* cpuTop.sv */
module cpuTop #(
	parameter int imemWords = 64,
	parameter int dmemWords = 32
) (
	input logic clk,
	input logic reset,
	input logic progWrite,
	input isaPkg::wordT progAddr,
	input isaPkg::wordT progData,
	output logic commitValid,
	output isaPkg::regIdxT commitReg,
	output isaPkg::wordT commitData,
	output logic storeValid,
	output isaPkg::wordT storeAddr,
	output isaPkg::wordT storeData,
	output logic halted
);
	pipePkg::ifIdT ifId;
	pipePkg::idExT idEx;
	pipePkg::exMemT exMem;
	pipePkg::memWbT memWb;
	pipePkg::hazardSrcT hazEx;
	pipePkg::hazardSrcT hazMem;
	pipePkg::hazardSrcT hazWb;
	logic stall;
	logic redirect;
	logic haltSeen;
	isaPkg::wordT redirectPc;

	// In-flight writers for the decode hazard check
	assign hazEx = '{regWrite: idEx.valid && idEx.ctrl.regWrite, dest: idEx.dest};
	assign hazMem = '{regWrite: exMem.valid && exMem.ctrl.regWrite, dest: exMem.dest};
	assign hazWb = '{regWrite: memWb.valid && memWb.regWrite, dest: memWb.dest};

	assign commitValid = memWb.valid && memWb.regWrite;
	assign commitReg = memWb.dest;
	assign commitData = memWb.data;

	fetchStage #(.imemWords(imemWords)) u_fetchStage (
		.clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
		.progData(progData), .stall(stall), .redirect(redirect),
		.redirectPc(redirectPc), .haltSeen(haltSeen), .ifId(ifId)
	);

	decodeStage u_decodeStage (
		.clk(clk), .reset(reset), .ifId(ifId), .wb(memWb), .hazEx(hazEx),
		.hazMem(hazMem), .hazWb(hazWb), .stall(stall), .redirect(redirect),
		.redirectPc(redirectPc), .haltSeen(haltSeen), .idEx(idEx)
	);

	executeStage u_executeStage (
		.clk(clk), .reset(reset), .idEx(idEx), .exMem(exMem)
	);

	memoryStage #(.dmemWords(dmemWords)) u_memoryStage (
		.clk(clk), .reset(reset), .exMem(exMem), .memWb(memWb),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
		.halted(halted)
	);

endmodule

/* memoryStage.sv */
module memoryStage #(
	parameter int dmemWords = 32
) (
	input logic clk,
	input logic reset,
	input pipePkg::exMemT exMem,
	output pipePkg::memWbT memWb,
	output logic storeValid,
	output isaPkg::wordT storeAddr,
	output isaPkg::wordT storeData,
	output logic halted
);
	localparam int idxW = $clog2(dmemWords);

	isaPkg::wordT dmem [dmemWords];
	logic [idxW-1:0] memIdx;
	isaPkg::wordT loadData;

	// Upper address bits wrap onto the word index
	assign memIdx = exMem.result[idxW:1];
	assign loadData = dmem[memIdx];

	assign storeValid = exMem.valid && exMem.ctrl.memWrite;
	assign storeAddr = exMem.result;
	assign storeData = exMem.storeData;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dmemWords; i++) begin
				dmem[i] <= '0;
			end
		end else if (storeValid) begin
			dmem[memIdx] <= exMem.storeData;
		end
	end

	always_ff @(posedge clk) begin
		memWb.dest <= exMem.dest;
		memWb.data <= exMem.ctrl.memRead ? loadData : exMem.result;
		if (reset) begin
			memWb.valid <= 1'b0;
			memWb.regWrite <= 1'b0;
			memWb.halt <= 1'b0;
			halted <= 1'b0;
		end else begin
			memWb.valid <= exMem.valid;
			memWb.regWrite <= exMem.valid && exMem.ctrl.regWrite;
			memWb.halt <= exMem.valid && exMem.ctrl.halt;
			// Sticky once HALT leaves MEM/WB
			if (memWb.valid && memWb.halt) begin
				halted <= 1'b1;
			end
		end
	end

	memExclusive: assert property (@(posedge clk) disable iff (reset)
		exMem.valid |-> !(exMem.ctrl.memRead && exMem.ctrl.memWrite));

endmodule

/* executeStage.sv */
module executeStage (
	input logic clk,
	input logic reset,
	input pipePkg::idExT idEx,
	output pipePkg::exMemT exMem
);
	isaPkg::wordT opB;
	isaPkg::wordT result;

	assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : idEx.b;

	// Loads and stores use aluAdd for rs plus offset
	always_comb begin
		case (idEx.ctrl.aluOp)
			pipePkg::aluPassB: result = opB;
			pipePkg::aluAdd: result = idEx.a + opB;
			pipePkg::aluSubR: result = opB - idEx.a;
			pipePkg::aluXor: result = idEx.a ^ opB;
			pipePkg::aluAndn: result = idEx.a & ~opB;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		exMem.result <= result;
		exMem.storeData <= idEx.storeData;
		exMem.dest <= idEx.dest;
		if (reset) begin
			exMem.valid <= 1'b0;
			exMem.ctrl <= '0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.ctrl <= idEx.ctrl;
		end
	end

endmodule

/* decodeStage.sv */
module decodeStage (
	input logic clk,
	input logic reset,
	input pipePkg::ifIdT ifId,
	input pipePkg::memWbT wb,
	input pipePkg::hazardSrcT hazEx,
	input pipePkg::hazardSrcT hazMem,
	input pipePkg::hazardSrcT hazWb,
	output logic stall,
	output logic redirect,
	output isaPkg::wordT redirectPc,
	output logic haltSeen,
	output pipePkg::idExT idEx
);
	typedef enum logic [1:0] {immZero5, immSign5, immSign8, immSign11} immSelT;
	typedef enum logic [1:0] {dstRd, dstRt, dstRs, dstR7} destSelT;

	isaPkg::wordT regs [8];
	isaPkg::opcodeT opcode;
	isaPkg::regIdxT rs;
	isaPkg::regIdxT rt;
	isaPkg::regIdxT dest;
	isaPkg::wordT readA;
	isaPkg::wordT readB;
	isaPkg::wordT imm;
	pipePkg::ctrlT ctrlDec;
	immSelT immSel;
	destSelT destSel;
	logic isBeqz;
	logic isBnez;
	logic isJump;
	logic haltLatched;
	logic live;
	logic hazard;
	logic issue;

	function automatic logic hitsAny(isaPkg::regIdxT src, pipePkg::hazardSrcT h0,
			pipePkg::hazardSrcT h1, pipePkg::hazardSrcT h2);
		return (h0.regWrite && h0.dest == src) || (h1.regWrite && h1.dest == src) ||
			(h2.regWrite && h2.dest == src);
	endfunction

	assign opcode = isaPkg::opcodeOf(ifId.inst);
	assign rs = isaPkg::rsOf(ifId.inst);
	assign rt = isaPkg::rtOf(ifId.inst);

	always_comb begin
		ctrlDec = '0;
		immSel = immSign5;
		destSel = dstRt;
		isBeqz = 1'b0;
		isBnez = 1'b0;
		isJump = 1'b0;
		case (opcode)
			isaPkg::opHalt: ctrlDec.halt = 1'b1;
			isaPkg::opNop: ;
			isaPkg::opJ: begin
				isJump = 1'b1;
				immSel = immSign11;
			end
			isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori, isaPkg::opAndni: begin
				ctrlDec.regWrite = 1'b1;
				ctrlDec.aluSrcImm = 1'b1;
				if (opcode == isaPkg::opAddi)
					ctrlDec.aluOp = pipePkg::aluAdd;
				else if (opcode == isaPkg::opSubi)
					ctrlDec.aluOp = pipePkg::aluSubR;
				else if (opcode == isaPkg::opXori)
					ctrlDec.aluOp = pipePkg::aluXor;
				else
					ctrlDec.aluOp = pipePkg::aluAndn;
				// Logical immediates are zero extended
				if (opcode == isaPkg::opXori || opcode == isaPkg::opAndni)
					immSel = immZero5;
			end
			isaPkg::opBeqz: begin
				isBeqz = 1'b1;
				immSel = immSign8;
			end
			isaPkg::opBnez: begin
				isBnez = 1'b1;
				immSel = immSign8;
			end
			isaPkg::opSt: begin
				ctrlDec.memWrite = 1'b1;
				ctrlDec.aluSrcImm = 1'b1;
				ctrlDec.aluOp = pipePkg::aluAdd;
			end
			isaPkg::opLd: begin
				ctrlDec.memRead = 1'b1;
				ctrlDec.regWrite = 1'b1;
				ctrlDec.aluSrcImm = 1'b1;
				ctrlDec.aluOp = pipePkg::aluAdd;
			end
			isaPkg::opLbi: begin
				ctrlDec.regWrite = 1'b1;
				ctrlDec.aluSrcImm = 1'b1;
				ctrlDec.aluOp = pipePkg::aluPassB;
				immSel = immSign8;
				destSel = dstRs;
			end
			isaPkg::opRtype: begin
				ctrlDec.regWrite = 1'b1;
				destSel = dstRd;
				case (isaPkg::functOf(ifId.inst))
					isaPkg::fnAdd: ctrlDec.aluOp = pipePkg::aluAdd;
					isaPkg::fnSub: ctrlDec.aluOp = pipePkg::aluSubR;
					isaPkg::fnXor: ctrlDec.aluOp = pipePkg::aluXor;
					default: ctrlDec.aluOp = pipePkg::aluAndn;
				endcase
			end
			default: ;
		endcase
	end

	always_comb begin
		case (immSel)
			immZero5: imm = {11'b0, ifId.inst[4:0]};
			immSign5: imm = {{11{ifId.inst[4]}}, ifId.inst[4:0]};
			immSign8: imm = {{8{ifId.inst[7]}}, ifId.inst[7:0]};
			default: imm = {{5{ifId.inst[10]}}, ifId.inst[10:0]};
		endcase
	end

	always_comb begin
		case (destSel)
			dstRd: dest = isaPkg::rdOf(ifId.inst);
			dstRt: dest = rt;
			dstRs: dest = rs;
			default: dest = 3'd7;
		endcase
	end

	// Register file written from MEM/WB and read combinationally
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && wb.regWrite) begin
			regs[wb.dest] <= wb.data;
		end
	end

	assign readA = regs[rs];
	assign readB = regs[rt];

	// Both fields checked even when unused, so some stalls are false
	assign live = ifId.valid && !haltLatched;
	assign hazard = live && (hitsAny(rs, hazEx, hazMem, hazWb) ||
		hitsAny(rt, hazEx, hazMem, hazWb));
	assign issue = live && !hazard;
	assign stall = hazard;

	assign redirect = issue && (isJump || (isBeqz && readA == '0) || (isBnez && readA != '0));
	assign redirectPc = ifId.pc + isaPkg::wordT'(2) + imm;
	assign haltSeen = haltLatched || (issue && ctrlDec.halt);

	always_ff @(posedge clk) begin
		idEx.a <= readA;
		idEx.b <= readB;
		idEx.storeData <= readB;
		idEx.imm <= imm;
		idEx.dest <= dest;
		if (reset) begin
			idEx.valid <= 1'b0;
			idEx.ctrl <= '0;
			haltLatched <= 1'b0;
		end else begin
			idEx.valid <= issue;
			// Bubble on a hazard
			idEx.ctrl <= issue ? ctrlDec : '0;
			if (haltSeen) begin
				haltLatched <= 1'b1;
			end
		end
	end

	// A taken branch never overlaps a stall and always squashes the next fetch
	redirectSquash: assert property (@(posedge clk) disable iff (reset)
		redirect |-> !stall ##1 !ifId.valid);

endmodule

/* fetchStage.sv */
module fetchStage #(
	parameter int imemWords = 64
) (
	input logic clk,
	input logic reset,
	input logic progWrite,
	input isaPkg::wordT progAddr,
	input isaPkg::wordT progData,
	input logic stall,
	input logic redirect,
	input isaPkg::wordT redirectPc,
	input logic haltSeen,
	output pipePkg::ifIdT ifId
);
	localparam int idxW = $clog2(imemWords);

	isaPkg::wordT imem [imemWords];
	isaPkg::wordT pc;
	logic [idxW-1:0] fetchIdx;

	// PC is a byte address and memory holds words
	assign fetchIdx = pc[idxW:1];

	// Program load uses byte addresses like the PC
	always_ff @(posedge clk) begin
		if (reset && progWrite) begin
			imem[progAddr[idxW:1]] <= progData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			ifId.valid <= 1'b0;
		end else if (redirect) begin
			pc <= redirectPc;
			ifId.valid <= 1'b0;
		end else if (stall || haltSeen) begin
			// Hold on a hazard and freeze after HALT
			pc <= pc;
		end else begin
			pc <= pc + isaPkg::wordT'(2);
			ifId.valid <= 1'b1;
			ifId.pc <= pc;
			ifId.inst <= imem[fetchIdx];
		end
	end

	pcEven: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0);

endmodule

/* pipePkg.sv */
package pipePkg;

	// SUBR computes operand B minus operand A
	typedef enum logic [2:0] {
		aluPassB,
		aluAdd,
		aluSubR,
		aluXor,
		aluAndn
	} aluOpT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic halt;
		aluOpT aluOp;
		logic aluSrcImm;
	} ctrlT;

	typedef struct packed {
		logic valid;
		isaPkg::wordT pc;
		isaPkg::wordT inst;
	} ifIdT;

	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		isaPkg::wordT a;
		isaPkg::wordT b;
		isaPkg::wordT storeData;
		isaPkg::wordT imm;
		isaPkg::regIdxT dest;
	} idExT;

	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		isaPkg::wordT result;
		isaPkg::wordT storeData;
		isaPkg::regIdxT dest;
	} exMemT;

	typedef struct packed {
		logic valid;
		logic regWrite;
		logic halt;
		isaPkg::regIdxT dest;
		isaPkg::wordT data;
	} memWbT;

	// One in-flight writer, as seen by the hazard check
	typedef struct packed {
		logic regWrite;
		isaPkg::regIdxT dest;
	} hazardSrcT;

endpackage

/* isaPkg.sv */
package isaPkg;

	localparam int wordW = 16;
	localparam int regIdxW = 3;
	localparam int opcodeW = 5;
	localparam int functW = 2;

	// Instruction field positions
	localparam int opcodeHi = 15;
	localparam int opcodeLo = 11;
	localparam int rsHi = 10;
	localparam int rsLo = 8;
	localparam int rtHi = 7;
	localparam int rtLo = 5;
	localparam int rdHi = 4;
	localparam int rdLo = 2;
	localparam int functHi = 1;
	localparam int functLo = 0;

	typedef logic [wordW-1:0] wordT;
	typedef logic [regIdxW-1:0] regIdxT;

	typedef enum logic [opcodeW-1:0] {
		opHalt = 5'b00000,
		opNop = 5'b00001,
		opJ = 5'b00100,
		opAddi = 5'b01000,
		opSubi = 5'b01001,
		opXori = 5'b01010,
		opAndni = 5'b01011,
		opBeqz = 5'b01100,
		opBnez = 5'b01101,
		opSt = 5'b10000,
		opLd = 5'b10001,
		opLbi = 5'b11000,
		opRtype = 5'b11011
	} opcodeT;

	// SUB is rt minus rs
	typedef enum logic [functW-1:0] {
		fnAdd = 2'b00,
		fnSub = 2'b01,
		fnXor = 2'b10,
		fnAndn = 2'b11
	} functT;

	function automatic opcodeT opcodeOf(wordT inst);
		return opcodeT'(inst[opcodeHi:opcodeLo]);
	endfunction

	function automatic functT functOf(wordT inst);
		return functT'(inst[functHi:functLo]);
	endfunction

	function automatic regIdxT rsOf(wordT inst);
		return inst[rsHi:rsLo];
	endfunction

	function automatic regIdxT rtOf(wordT inst);
		return inst[rtHi:rtLo];
	endfunction

	function automatic regIdxT rdOf(wordT inst);
		return inst[rdHi:rdLo];
	endfunction

endpackage
